//--- hw/elevator_pkg.sv
// Elevator floor logic package with floor, state and mask types and the stop decode
`default_nettype none

package elevator_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Eleven landings, indexed 0 to 10 (floor 1 is index 0)
    localparam int NUM_FLOORS = 11;
    localparam int FLOOR_W    = 4;

    // Width of the state code reported by the motion FSM
    localparam int STATE_W    = 6;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [FLOOR_W-1:0]    floor_t;
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;
    typedef logic [STATE_W-1:0]    state_t;

    ////////////////////
    // Motion state codes
    ////////////////////

    // Code map of the motion FSM
    //   0 .. 10   stopped at floor code+1
    //   11 .. 20  moving up between two floors
    //   21 .. 30  moving down between two floors
    //   31        emergency
    localparam state_t STOP_LAST       = 6'd10;
    localparam state_t EMERGENCY_STATE = 6'd31;

    // True for any of the eleven stop codes
    function automatic logic is_stop_state(input state_t state);
        return state <= STOP_LAST;
    endfunction

endpackage

`default_nettype wire

//--- hw/request_if.sv
// Request bus with the pending call masks and the clear-at-landing strobe
`timescale 1ns/1ps
`default_nettype none

interface request_if import elevator_pkg::*; ();

    // Pending hall calls split by travel direction
    floor_mask_t up_pending;
    floor_mask_t down_pending;

    // Pending destinations from the car panel
    floor_mask_t car_pending;

    // High while powered and parked at a landing
    logic        stop_clear;

    modport keeper (
        output up_pending,
        output down_pending,
        output car_pending,
        input  stop_clear
    );

    modport dispatcher (
        input  up_pending,
        input  down_pending,
        input  car_pending,
        output stop_clear
    );

endinterface

`default_nettype wire

//--- hw/call_register.sv
// Call register that latches hall and car calls and drives the button lights
`timescale 1ns/1ps
`default_nettype none

module call_register import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        power_switch,
    input  floor_t      current_floor,
    input  floor_mask_t hall_buttons,
    input  floor_mask_t car_buttons,
    request_if.keeper   req,
    output floor_mask_t call_lights,
    output floor_mask_t car_lights
);

    floor_mask_t up_next;
    floor_mask_t down_next;
    floor_mask_t car_next;
    floor_mask_t hall_lit;

    // A floor has a lit hall lamp when it waits in either direction
    assign hall_lit = req.up_pending | req.down_pending;

    ////////////////////
    // Next request masks
    ////////////////////

    always_comb begin
        up_next   = req.up_pending;
        down_next = req.down_pending;
        car_next  = req.car_pending;

        // Landing reached, so every request at this floor is served
        if (req.stop_clear) begin
            up_next[current_floor]   = 1'b0;
            down_next[current_floor] = 1'b0;
            car_next[current_floor]  = 1'b0;
        end

        for (int f = 0; f < NUM_FLOORS; f++) begin
            // Presses at the car's own floor are ignored
            if (floor_t'(f) != current_floor) begin
                // A lit hall call keeps the direction it was first given
                if (hall_buttons[f] && !hall_lit[f]) begin
                    if (floor_t'(f) > current_floor) begin
                        up_next[f] = 1'b1;
                    end else begin
                        down_next[f] = 1'b1;
                    end
                end
                if (car_buttons[f]) begin
                    car_next[f] = 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Request registers
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            req.up_pending   <= '0;
            req.down_pending <= '0;
            req.car_pending  <= '0;
        end else if (!power_switch) begin
            // Power loss drops every call
            req.up_pending   <= '0;
            req.down_pending <= '0;
            req.car_pending  <= '0;
        end else begin
            req.up_pending   <= up_next;
            req.down_pending <= down_next;
            req.car_pending  <= car_next;
        end
    end

    // Lamps show the registered state directly
    assign call_lights = hall_lit;
    assign car_lights  = req.car_pending;

    ////////////////////
    // Checks
    ////////////////////

    // One hall call per floor, never both directions at once
    assert property (@(posedge clock) disable iff (!reset_n)
        (req.up_pending & req.down_pending) == '0)
        else $error("call_register: up and down call pending at the same floor");

endmodule

`default_nettype wire

//--- hw/dispatch_controller.sv
// Dispatch controller that picks the next target floor and grants door requests
`timescale 1ns/1ps
`default_nettype none

module dispatch_controller import elevator_pkg::*; (
    input  logic          power_switch,
    input  logic          emergency_btn,
    input  logic          door_open_btn,
    input  logic          door_close_btn,
    input  floor_t        current_floor,
    input  state_t        elevator_state,
    request_if.dispatcher req,
    output floor_t        target_floor,
    output logic          direction_up,
    output logic          activate_elevator,
    output logic          door_open_allowed,
    output logic          door_close_allowed
);

    logic        stopped;
    logic        inhibit;
    floor_mask_t above_mask;
    floor_mask_t below_mask;
    floor_mask_t pass1_mask;
    floor_mask_t pass2_mask;
    floor_mask_t pass3_mask;
    floor_mask_t pass4_mask;

    // Highest set bit of a floor mask, 0 when the mask is empty
    function automatic floor_t highest_floor(input floor_mask_t mask);
        floor_t idx;
        idx = '0;
        for (int f = 0; f < NUM_FLOORS; f++) begin
            if (mask[f]) begin
                idx = floor_t'(f);
            end
        end
        return idx;
    endfunction

    // Lowest set bit of a floor mask, 0 when the mask is empty
    function automatic floor_t lowest_floor(input floor_mask_t mask);
        floor_t idx;
        idx = '0;
        for (int f = NUM_FLOORS - 1; f >= 0; f--) begin
            if (mask[f]) begin
                idx = floor_t'(f);
            end
        end
        return idx;
    endfunction

    ////////////////////
    // Stop decode
    ////////////////////

    // Parked at a landing with power on
    assign stopped        = power_switch && is_stop_state(elevator_state);
    assign req.stop_clear = stopped;

    // Emergency stop from the car button
    assign inhibit = emergency_btn;

    ////////////////////
    // Target selection
    ////////////////////

    always_comb begin
        for (int f = 0; f < NUM_FLOORS; f++) begin
            above_mask[f] = floor_t'(f) > current_floor;
            below_mask[f] = floor_t'(f) < current_floor;
        end

        // Candidates of the four passes, in priority order
        pass1_mask = (req.up_pending | req.car_pending) & above_mask;
        pass2_mask = (req.down_pending | req.car_pending) & below_mask;
        pass3_mask = req.down_pending & above_mask;
        pass4_mask = req.up_pending & below_mask;

        target_floor      = '0;
        direction_up      = 1'b0;
        activate_elevator = 1'b0;

        if (stopped && !inhibit) begin
            if (|pass1_mask) begin
                target_floor      = highest_floor(pass1_mask);
                direction_up      = 1'b1;
                activate_elevator = 1'b1;
            end else if (|pass2_mask) begin
                target_floor      = lowest_floor(pass2_mask);
                direction_up      = 1'b0;
                activate_elevator = 1'b1;
            end else if (|pass3_mask) begin
                // Go up to meet a down call, sweep the far end first
                target_floor      = highest_floor(pass3_mask);
                direction_up      = 1'b1;
                activate_elevator = 1'b1;
            end else if (|pass4_mask) begin
                target_floor      = lowest_floor(pass4_mask);
                direction_up      = 1'b0;
                activate_elevator = 1'b1;
            end
        end

        // Registered masks never hold the car's own floor as a target
        if (activate_elevator) begin
            assert (target_floor != current_floor)
                else $error("dispatch_controller: target equals current floor");
        end
    end

    ////////////////////
    // Door permission
    ////////////////////

    // Doors only respond while parked with power on
    assign door_open_allowed  = stopped && door_open_btn;
    assign door_close_allowed = stopped && door_close_btn;

endmodule

`default_nettype wire

//--- hw/floor_logic_top.sv
// Elevator floor logic top level joining the call register and the dispatcher
`timescale 1ns/1ps
`default_nettype none

module floor_logic_top import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    // Buttons, high while pressed
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,
    // Status from the motion FSM
    input  floor_t      current_floor_state,
    input  state_t      elevator_state,
    // Commands to the motion FSM
    output floor_t      elevator_floor_selector,
    output logic        direction_selector,
    output logic        activate_elevator,
    // Lamps
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    request_if req_bus ();

    ////////////////////
    // Request stage
    ////////////////////

    call_register call_register_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .power_switch  (power_switch),
        .current_floor (current_floor_state),
        .hall_buttons  (floor_call_buttons),
        .car_buttons   (panel_buttons),
        .req           (req_bus.keeper),
        .call_lights   (call_button_lights),
        .car_lights    (panel_button_lights)
    );

    ////////////////////
    // Dispatch stage
    ////////////////////

    dispatch_controller dispatch_controller_inst (
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .current_floor      (current_floor_state),
        .elevator_state     (elevator_state),
        .req                (req_bus.dispatcher),
        .target_floor       (elevator_floor_selector),
        .direction_up       (direction_selector),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// Testbench clock and reset generator with a 40 ns clock and a two-cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 2;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Release away from the rising edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/floor_logic_tb.sv
// Testbench for the elevator floor logic with directed tests of calls, dispatch and doors
`timescale 1ns/1ps
`default_nettype none

module floor_logic_tb import elevator_pkg::*; ();

    localparam int CLOCK_PERIOD   = 40;
    localparam int RESET_CYCLES   = 4;
    localparam int LIGHT_CYCLES   = 6;
    localparam int PASS12_CYCLES  = 8;
    localparam int PASS34_CYCLES  = 10;
    localparam int INHIBIT_CYCLES = 8;
    localparam int DOOR_ROUNDS    = 8;
    localparam int DOOR_CYCLES    = DOOR_ROUNDS * 3 + 2;
    localparam int MARGIN_CYCLES  = 40;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + LIGHT_CYCLES + PASS12_CYCLES
                                  + PASS34_CYCLES + INHIBIT_CYCLES + DOOR_CYCLES
                                  + MARGIN_CYCLES;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor_state;
    state_t      elevator_state;
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    int          error_count;
    int          check_count;
    int          test_count;
    int unsigned seed_value;

    tb_clock_gen tb_clock_gen_inst (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_logic_top floor_logic_top_inst (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor_state     (current_floor_state),
        .elevator_state          (elevator_state),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic floor_mask_t one_floor(input int f);
        floor_mask_t mask;
        mask    = '0;
        mask[f] = 1'b1;
        return mask;
    endfunction

    // Doors respond only while parked with power on
    function automatic logic door_expected(input logic btn, input logic parked,
                                           input logic powered);
        return btn && parked && powered;
    endfunction

    task automatic next_cycle();
        @(negedge clock);
    endtask

    task automatic let_settle();
        #1;
    endtask

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        $display("Test %0d %s done with %0d errors", test_count, name,
                 error_count - errors_before);
    endtask

    // Hold buttons over one rising edge, then release
    task automatic press_buttons(input floor_mask_t hall, input floor_mask_t panel);
        floor_call_buttons = hall;
        panel_buttons      = panel;
        next_cycle();
        floor_call_buttons = '0;
        panel_buttons      = '0;
    endtask

    // Stop code c means parked at index c
    task automatic park_at(input int f);
        current_floor_state = floor_t'(f);
        elevator_state      = state_t'(f);
    endtask

    task automatic drop_calls();
        power_switch = 1'b0;
        next_cycle();
        power_switch = 1'b1;
    endtask

    task automatic check_dispatch(input int target, input int up, input int active);
        check_equal("target floor", elevator_floor_selector, target);
        check_equal("direction up", direction_selector, up);
        check_equal("activate", activate_elevator, active);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_reset_and_lights();
        int errors_before;
        errors_before       = error_count;
        current_floor_state = 4'd5;
        elevator_state      = 6'd12;
        let_settle();
        check_dispatch(0, 0, 0);
        check_equal("call lights after reset", call_button_lights, 0);
        check_equal("panel lights after reset", panel_button_lights, 0);
        check_equal("door open after reset", door_open_allowed, 0);
        check_equal("door close after reset", door_close_allowed, 0);
        // Presses at floor 5 itself must stay dark
        press_buttons(one_floor(8) | one_floor(2) | one_floor(5), one_floor(9) | one_floor(5));
        let_settle();
        check_equal("call lights", call_button_lights, one_floor(8) | one_floor(2));
        check_equal("panel lights", panel_button_lights, one_floor(9));
        check_equal("activate while moving", activate_elevator, 0);
        drop_calls();
        end_test("reset and lights", errors_before);
    endtask

    task automatic test_passes_up_down();
        int errors_before;
        errors_before = error_count;
        park_at(4);
        press_buttons('0, one_floor(2) | one_floor(8));
        let_settle();
        check_equal("panel lights", panel_button_lights, one_floor(2) | one_floor(8));
        check_dispatch(8, 1, 1);
        // Travelling up
        current_floor_state = 4'd6;
        elevator_state      = 6'd15;
        let_settle();
        check_equal("activate while moving", activate_elevator, 0);
        next_cycle();
        park_at(8);
        let_settle();
        check_dispatch(2, 0, 1);
        next_cycle();
        let_settle();
        check_equal("panel lights after arrival", panel_button_lights, one_floor(2));
        check_dispatch(2, 0, 1);
        drop_calls();
        end_test("dispatch passes 1 and 2", errors_before);
    endtask

    task automatic test_passes_reverse();
        int errors_before;
        errors_before = error_count;
        // Call below a car moving down becomes a down call
        current_floor_state = 4'd9;
        elevator_state      = 6'd25;
        press_buttons(one_floor(6), '0);
        let_settle();
        check_equal("call lights", call_button_lights, one_floor(6));
        check_equal("activate while moving", activate_elevator, 0);
        park_at(1);
        let_settle();
        check_dispatch(6, 1, 1);
        drop_calls();
        // Call above a car at the bottom becomes an up call
        current_floor_state = 4'd0;
        elevator_state      = 6'd11;
        press_buttons(one_floor(3), '0);
        park_at(7);
        let_settle();
        check_equal("call lights", call_button_lights, one_floor(3));
        check_dispatch(3, 0, 1);
        drop_calls();
        end_test("dispatch passes 3 and 4", errors_before);
    endtask

    task automatic test_inhibits();
        int errors_before;
        errors_before = error_count;
        park_at(2);
        press_buttons(one_floor(9), one_floor(6));
        let_settle();
        check_dispatch(9, 1, 1);
        emergency_btn = 1'b1;
        let_settle();
        check_dispatch(0, 0, 0);
        emergency_btn = 1'b0;
        let_settle();
        check_dispatch(9, 1, 1);
        power_switch = 1'b0;
        let_settle();
        check_equal("activate with power off", activate_elevator, 0);
        check_equal("call lights before edge", call_button_lights, one_floor(9));
        next_cycle();
        let_settle();
        check_equal("call lights after power off", call_button_lights, 0);
        check_equal("panel lights after power off", panel_button_lights, 0);
        power_switch = 1'b1;
        let_settle();
        check_dispatch(0, 0, 0);
        end_test("inhibits", errors_before);
    endtask

    task automatic test_doors();
        int errors_before;
        int f;
        errors_before = error_count;
        for (int round = 0; round < DOOR_ROUNDS; round++) begin
            f              = int'($urandom % NUM_FLOORS);
            door_open_btn  = 1'($urandom % 2);
            door_close_btn = 1'($urandom % 2);
            // Parked and powered
            park_at(f);
            let_settle();
            check_equal("door open parked", door_open_allowed,
                        door_expected(door_open_btn, 1'b1, 1'b1));
            check_equal("door close parked", door_close_allowed,
                        door_expected(door_close_btn, 1'b1, 1'b1));
            next_cycle();
            // Moving
            elevator_state = state_t'(11 + ($urandom % 20));
            let_settle();
            check_equal("door open moving", door_open_allowed,
                        door_expected(door_open_btn, 1'b0, 1'b1));
            check_equal("door close moving", door_close_allowed,
                        door_expected(door_close_btn, 1'b0, 1'b1));
            next_cycle();
            // Parked with power off
            park_at(f);
            power_switch = 1'b0;
            let_settle();
            check_equal("door open unpowered", door_open_allowed,
                        door_expected(door_open_btn, 1'b1, 1'b0));
            check_equal("door close unpowered", door_close_allowed,
                        door_expected(door_close_btn, 1'b1, 1'b0));
            next_cycle();
            power_switch = 1'b1;
        end
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        end_test("doors", errors_before);
    endtask

    ////////////////////
    // Run control
    ////////////////////

    initial begin
        floor_call_buttons  = '0;
        panel_buttons       = '0;
        door_open_btn       = 1'b0;
        door_close_btn      = 1'b0;
        emergency_btn       = 1'b0;
        power_switch        = 1'b1;
        current_floor_state = '0;
        elevator_state      = 6'd12;
        error_count         = 0;
        check_count         = 0;
        test_count          = 0;
        seed_value          = 7959;
        void'($urandom(seed_value));

        @(posedge reset_n);
        next_cycle();

        test_reset_and_lights();
        test_passes_up_down();
        test_passes_reverse();
        test_inhibits();
        test_doors();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the cycle budget of all tests
    initial begin
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("Watchdog: the run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- floor_logic.f
hw/elevator_pkg.sv
hw/request_if.sv
hw/call_register.sv
hw/dispatch_controller.sv
hw/floor_logic_top.sv
tb/tb_clock_gen.sv
tb/floor_logic_tb.sv
